// ==== verilog/rgb_settings.svh ====
`ifndef RGB_SETTINGS_SVH
`define RGB_SETTINGS_SVH

// Geometry of one µblock
`define RGB_BLK_W 8
`define RGB_BLK_H 16

// Frame size in µblocks
`define RGB_BLK_COLS 5
`define RGB_BLK_LINES 4

// Derived sizes
`define RGB_BLK_PIXELS (`RGB_BLK_W * `RGB_BLK_H)
`define RGB_FRAME_PIXELS (`RGB_BLK_PIXELS * `RGB_BLK_COLS * `RGB_BLK_LINES)

// Credits granted to the block reader after reset
`define RGB_CREDITS 4

// Two frame banks in the pixel memory
`define RGB_RAM_DEPTH (2 * `RGB_FRAME_PIXELS)

`endif

// ==== verilog/video_pkg.sv ====
`include "rgb_settings.svh"

package video_pkg;

    // One RGB888 pixel
    typedef logic [23:0] pixel_t;

    // Position inside a µblock
    typedef logic [$clog2(`RGB_BLK_W)-1:0] pixel_col_t;
    typedef logic [$clog2(`RGB_BLK_H)-1:0] pixel_line_t;

    // Position of the µblock inside the frame
    typedef logic [$clog2(`RGB_BLK_COLS)-1:0] block_col_t;
    typedef logic [$clog2(`RGB_BLK_LINES)-1:0] block_line_t;

    localparam int BLK_ADDR_W = $bits(block_line_t) + $bits(block_col_t)
                              + $bits(pixel_line_t) + $bits(pixel_col_t);

    // Word offset inside a bank, seen flat or by coordinates
    typedef union packed {
        logic [BLK_ADDR_W-1:0] linear;
        struct packed {
            block_line_t block_line;
            block_col_t  block_col;
            pixel_line_t pixel_line;
            pixel_col_t  pixel_col;
        } fields;
    } block_addr_u;

endpackage

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // Bank select on top of the in-bank offset
    typedef logic [video_pkg::BLK_ADDR_W:0] ram_addr_t;

    // Memory holds pixels as they arrive
    typedef video_pkg::pixel_t ram_word_t;

    // Owners of the single RAM port
    typedef enum logic {
        REQ_WRITER,
        REQ_READER
    } requester_e;

endpackage

// ==== verilog/rgb_logic.sv ====
`timescale 1ns/1ps
`include "rgb_settings.svh"

module rgb_logic
    import video_pkg::*;
(
    input  logic        rgb_clk,
    input  logic        nrst,

    input  pixel_t      rgb,
    input  logic        hsync,
    input  logic        vsync,

    // Pixel output, one cycle after the sample
    output pixel_t      pixel_data,
    output logic [31:0] pixel_idx,
    output logic        pixel_valid,

    // Coordinates of the pixel inside its µblock
    output pixel_col_t  pixel_col,
    output pixel_line_t pixel_line,
    // Coordinates of the µblock
    output block_col_t  block_col,
    output block_line_t block_line,

    // Capture enable, sampled once per frame
    input  logic        rgb_enable
);

    logic        vsync_r;
    logic        frame_start;
    logic        step;
    logic        frame_en;

    // Coordinates of the pixel currently on the bus
    logic [31:0] cnt_idx;
    pixel_col_t  cnt_pixel_col;
    pixel_line_t cnt_pixel_line;
    block_col_t  cnt_block_col;
    block_line_t cnt_block_line;

    assign frame_start = vsync & ~vsync_r;
    assign step        = vsync & vsync_r & hsync;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            vsync_r  <= 1'b0;
            frame_en <= 1'b0;
        end else begin
            vsync_r <= vsync;
            if (frame_start)
                frame_en <= rgb_enable;
        end
    end

    // Pixel column inside µblock column inside pixel line inside µblock line
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            cnt_idx        <= '0;
            cnt_pixel_col  <= '0;
            cnt_pixel_line <= '0;
            cnt_block_col  <= '0;
            cnt_block_line <= '0;
        end else if (frame_start) begin
            cnt_idx        <= '0;
            cnt_pixel_col  <= '0;
            cnt_pixel_line <= '0;
            cnt_block_col  <= '0;
            cnt_block_line <= '0;
        end else if (step) begin
            cnt_idx       <= cnt_idx + 32'd1;
            cnt_pixel_col <= cnt_pixel_col + 1'b1;
            if (cnt_pixel_col == pixel_col_t'(`RGB_BLK_W - 1)) begin
                cnt_pixel_col <= '0;
                cnt_block_col <= cnt_block_col + 1'b1;
                if (cnt_block_col == block_col_t'(`RGB_BLK_COLS - 1)) begin
                    cnt_block_col  <= '0;
                    cnt_pixel_line <= cnt_pixel_line + 1'b1;
                    if (cnt_pixel_line == pixel_line_t'(`RGB_BLK_H - 1)) begin
                        cnt_pixel_line <= '0;
                        cnt_block_line <= cnt_block_line + 1'b1;
                        if (cnt_block_line == block_line_t'(`RGB_BLK_LINES - 1))
                            cnt_block_line <= '0;
                    end
                end
            end
        end
    end

    // Valid only inside an enabled frame
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst)
            pixel_valid <= 1'b0;
        else
            pixel_valid <= step & frame_en;
    end

    // Data and coordinates latched together
    always_ff @(posedge rgb_clk) begin
        pixel_data <= rgb;
        pixel_idx  <= cnt_idx;
        pixel_col  <= cnt_pixel_col;
        pixel_line <= cnt_pixel_line;
        block_col  <= cnt_block_col;
        block_line <= cnt_block_line;
    end

endmodule

// ==== verilog/frame_writer.sv ====
`timescale 1ns/1ps
`include "rgb_settings.svh"

module frame_writer
    import video_pkg::*;
    import mem_pkg::*;
(
    input  logic        rgb_clk,
    input  logic        nrst,

    // Pixel stream from the video front end
    input  pixel_t      pixel_data,
    input  logic [31:0] pixel_idx,
    input  logic        pixel_valid,
    input  pixel_col_t  pixel_col,
    input  pixel_line_t pixel_line,
    input  block_col_t  block_col,
    input  block_line_t block_line,

    // Write request, always granted in the same cycle
    output logic        wr_req,
    output ram_addr_t   wr_addr,
    output ram_word_t   wr_data,

    // Bank holding the last complete frame
    output logic        ready_bank,
    output logic        frame_ready
);

    block_addr_u blk_addr;
    logic        frame_done;

    // Pixels of one µblock end up contiguous
    always_comb begin
        blk_addr.fields.block_line = block_line;
        blk_addr.fields.block_col  = block_col;
        blk_addr.fields.pixel_line = pixel_line;
        blk_addr.fields.pixel_col  = pixel_col;
    end

    // Fill the bank the reader is not using
    assign wr_req  = pixel_valid;
    assign wr_addr = {~ready_bank, blk_addr.linear};
    assign wr_data = pixel_data;

    assign frame_done = pixel_valid && (pixel_idx == 32'(`RGB_FRAME_PIXELS - 1));

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            ready_bank  <= 1'b0;
            frame_ready <= 1'b0;
        end else if (frame_done) begin
            ready_bank  <= ~ready_bank;
            frame_ready <= 1'b1;
        end
    end

endmodule

// ==== verilog/ram_arbiter.sv ====
`timescale 1ns/1ps

module ram_arbiter
    import mem_pkg::*;
(
    // Writer side, never stalled
    input  logic       wr_req,
    input  ram_addr_t  wr_addr,
    input  ram_word_t  wr_data,

    // Reader side, holds its request until granted
    input  logic       rd_req,
    input  ram_addr_t  rd_addr,
    output logic       rd_gnt,

    // Single RAM port
    output logic       ram_we,
    output ram_addr_t  ram_addr,
    output ram_word_t  ram_wdata
);

    requester_e owner;

    // Writer wins whenever it asks
    always_comb begin
        if (wr_req)
            owner = REQ_WRITER;
        else
            owner = REQ_READER;
    end

    assign rd_gnt = rd_req && (owner == REQ_READER);
    assign ram_we = (owner == REQ_WRITER);

    always_comb begin
        case (owner)
            REQ_WRITER: ram_addr = wr_addr;
            default:    ram_addr = rd_addr;
        endcase
    end

    // Only the writer drives data
    assign ram_wdata = wr_data;

endmodule

// ==== verilog/frame_ram.sv ====
`timescale 1ns/1ps
`include "rgb_settings.svh"

module frame_ram
    import mem_pkg::*;
(
    input  logic      rgb_clk,
    input  logic      ram_we,
    input  ram_addr_t ram_addr,
    input  ram_word_t ram_wdata,
    output ram_word_t ram_rdata
);

    localparam int DEPTH      = `RGB_RAM_DEPTH;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int OFFSET_W   = $bits(ram_addr_t) - 1;
    localparam int ROW_BITS   = $clog2(`RGB_BLK_PIXELS) + $clog2(`RGB_BLK_COLS);
    localparam int BANK_WORDS = `RGB_FRAME_PIXELS;
    localparam int ROW_WORDS  = `RGB_BLK_COLS * `RGB_BLK_PIXELS;

    ram_word_t        mem [DEPTH];
    logic [IDX_W-1:0] index;

    // Unused µblock column slots are squeezed out of each µblock row
    always_comb begin
        index = (ram_addr[OFFSET_W] ? IDX_W'(BANK_WORDS) : '0)
              + IDX_W'(ram_addr[OFFSET_W-1:ROW_BITS]) * IDX_W'(ROW_WORDS)
              + IDX_W'(ram_addr[ROW_BITS-1:0]);
    end

    always_ff @(posedge rgb_clk) begin
        if (ram_we)
            mem[index] <= ram_wdata;
        ram_rdata <= mem[index];
    end

endmodule

// ==== verilog/block_reader.sv ====
`timescale 1ns/1ps
`include "rgb_settings.svh"

module block_reader
    import video_pkg::*;
    import mem_pkg::*;
(
    input  logic        rgb_clk,
    input  logic        nrst,

    // Host request
    input  logic        rd_start,
    input  block_col_t  rd_block_col,
    input  block_line_t rd_block_line,
    input  logic        credit_return,

    // Bank handover from the writer
    input  logic        ready_bank,
    input  logic        frame_ready,

    // RAM access through the arbiter
    output logic        rd_req,
    output ram_addr_t   rd_addr,
    input  logic        rd_gnt,
    input  ram_word_t   ram_rdata,

    // Pixel stream to the host
    output logic        rd_busy,
    output pixel_t      out_data,
    output logic        out_valid,
    output logic        out_last
);

    localparam int CREDIT_W = 8;
    localparam int OFFS_W   = $clog2(`RGB_BLK_PIXELS);
    localparam int COL_W    = $bits(pixel_col_t);
    localparam logic [OFFS_W-1:0] LAST_OFFS = OFFS_W'(`RGB_BLK_PIXELS - 1);

    logic                start_ok;
    logic                bank_r;
    block_col_t          col_r;
    block_line_t         line_r;
    logic [OFFS_W-1:0]   req_offs;
    logic                req_done;
    logic [CREDIT_W-1:0] credits;
    logic                gnt_q;
    logic                last_q;
    block_addr_u         blk_addr;

    // Starts while busy or before the first frame are dropped
    assign start_ok = rd_start && !rd_busy && frame_ready;

    always_comb begin
        blk_addr.fields.block_line = line_r;
        blk_addr.fields.block_col  = col_r;
        blk_addr.fields.pixel_line = req_offs[OFFS_W-1:COL_W];
        blk_addr.fields.pixel_col  = req_offs[COL_W-1:0];
    end

    assign rd_addr = {bank_r, blk_addr.linear};

    // Credits still free once the read in flight is counted
    assign rd_req = rd_busy && !req_done && (credits > CREDIT_W'(gnt_q));

    // Read data returns one cycle after the grant
    assign out_valid = gnt_q;
    assign out_last  = last_q;
    assign out_data  = ram_rdata;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            rd_busy  <= 1'b0;
            req_done <= 1'b0;
            req_offs <= '0;
            gnt_q    <= 1'b0;
            last_q   <= 1'b0;
            credits  <= CREDIT_W'(`RGB_CREDITS);
        end else begin
            gnt_q   <= rd_gnt;
            last_q  <= rd_gnt && (req_offs == LAST_OFFS);
            credits <= credits - CREDIT_W'(gnt_q) + CREDIT_W'(credit_return);

            if (start_ok) begin
                rd_busy  <= 1'b1;
                req_done <= 1'b0;
                req_offs <= '0;
            end else begin
                if (rd_gnt) begin
                    req_offs <= req_offs + 1'b1;
                    if (req_offs == LAST_OFFS)
                        req_done <= 1'b1;
                end
                if (out_last)
                    rd_busy <= 1'b0;
            end
        end
    end

    // Bank frozen for the whole block
    always_ff @(posedge rgb_clk) begin
        if (start_ok) begin
            bank_r <= ready_bank;
            col_r  <= rd_block_col;
            line_r <= rd_block_line;
        end
    end

endmodule

// ==== verilog/block_capture_top.sv ====
`timescale 1ns/1ps

module block_capture_top
    import video_pkg::*;
    import mem_pkg::*;
(
    input  logic        rgb_clk,
    input  logic        nrst,

    // Parallel video input
    input  pixel_t      rgb,
    input  logic        hsync,
    input  logic        vsync,
    input  logic        rgb_enable,

    // Host block read
    input  logic        rd_start,
    input  block_col_t  rd_block_col,
    input  block_line_t rd_block_line,
    input  logic        credit_return,
    output pixel_t      out_data,
    output logic        out_valid,
    output logic        out_last,
    output logic        rd_busy,
    output logic        frame_ready
);

    pixel_t      pixel_data;
    logic [31:0] pixel_idx;
    logic        pixel_valid;
    pixel_col_t  pixel_col;
    pixel_line_t pixel_line;
    block_col_t  block_col;
    block_line_t block_line;

    logic        wr_req;
    ram_addr_t   wr_addr;
    ram_word_t   wr_data;
    logic        ready_bank;

    logic        rd_req;
    ram_addr_t   rd_addr;
    logic        rd_gnt;

    logic        ram_we;
    ram_addr_t   ram_addr;
    ram_word_t   ram_wdata;
    ram_word_t   ram_rdata;

    rgb_logic rgb_logic0 (
        .rgb_clk     (rgb_clk),
        .nrst        (nrst),
        .rgb         (rgb),
        .hsync       (hsync),
        .vsync       (vsync),
        .pixel_data  (pixel_data),
        .pixel_idx   (pixel_idx),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_line  (pixel_line),
        .block_col   (block_col),
        .block_line  (block_line),
        .rgb_enable  (rgb_enable)
    );

    frame_writer frame_writer0 (
        .rgb_clk     (rgb_clk),
        .nrst        (nrst),
        .pixel_data  (pixel_data),
        .pixel_idx   (pixel_idx),
        .pixel_valid (pixel_valid),
        .pixel_col   (pixel_col),
        .pixel_line  (pixel_line),
        .block_col   (block_col),
        .block_line  (block_line),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .ready_bank  (ready_bank),
        .frame_ready (frame_ready)
    );

    ram_arbiter ram_arbiter0 (
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_gnt    (rd_gnt),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    frame_ram frame_ram0 (
        .rgb_clk   (rgb_clk),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

    block_reader block_reader0 (
        .rgb_clk       (rgb_clk),
        .nrst          (nrst),
        .rd_start      (rd_start),
        .rd_block_col  (rd_block_col),
        .rd_block_line (rd_block_line),
        .credit_return (credit_return),
        .ready_bank    (ready_bank),
        .frame_ready   (frame_ready),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_gnt        (rd_gnt),
        .ram_rdata     (ram_rdata),
        .rd_busy       (rd_busy),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_last      (out_last)
    );

endmodule

// ==== verification/tb_block_capture.sv ====
`timescale 1ns/1ps
`include "rgb_settings.svh"

module tb_block_capture
    import video_pkg::*;
();

    localparam int LINES        = `RGB_BLK_H * `RGB_BLK_LINES;
    localparam int COLS         = `RGB_BLK_W * `RGB_BLK_COLS;
    localparam int GAP          = 4;
    localparam int FRAME_CYCLES = LINES * (COLS + GAP) + 64;
    localparam int READ_CYCLES  = 600;
    localparam int NUM_FRAMES   = 3;
    localparam int NUM_READS    = 26;
    localparam int CYCLE_LIMIT  = NUM_FRAMES * FRAME_CYCLES + NUM_READS * READ_CYCLES;

    logic        rgb_clk;
    logic        nrst;
    pixel_t      rgb;
    logic        hsync;
    logic        vsync;
    logic        rgb_enable;
    logic        rd_start;
    block_col_t  rd_block_col;
    block_line_t rd_block_line;
    logic        credit_return;
    pixel_t      out_data;
    logic        out_valid;
    logic        out_last;
    logic        rd_busy;
    logic        frame_ready;

    // Last enabled frame, and the frame being driven
    pixel_t      model [LINES][COLS];
    pixel_t      capture [LINES][COLS];
    pixel_t      exp_q [$];

    logic [15:0] video_lfsr;
    logic [15:0] credit_lfsr;
    string       test_name;
    logic        withhold;
    logic        prev_last;
    int          valid_seen;
    int          credits_returned;
    int          credit_wait;
    int          read_count;
    int          reads_started;
    int          blocks_done;
    int          cycle_count;
    int          data_errs;
    int          proto_errs;
    int          credit_errs;

    block_capture_top dut0 (
        .rgb_clk       (rgb_clk),
        .nrst          (nrst),
        .rgb           (rgb),
        .hsync         (hsync),
        .vsync         (vsync),
        .rgb_enable    (rgb_enable),
        .rd_start      (rd_start),
        .rd_block_col  (rd_block_col),
        .rd_block_line (rd_block_line),
        .credit_return (credit_return),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .out_last      (out_last),
        .rd_busy       (rd_busy),
        .frame_ready   (frame_ready)
    );

    initial begin
        rgb_clk = 1'b0;
        forever #4 rgb_clk = ~rgb_clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] state, input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            bits  = {bits[30:0], state[0]};
        end
    endtask

    // One frame of LINES lines, idle gaps between lines
    task automatic drive_frame(input logic enable);
        logic [31:0] bits;
        @(posedge rgb_clk);
        rgb_enable <= enable;
        vsync      <= 1'b1;
        repeat (GAP) @(posedge rgb_clk);
        for (int y = 0; y < LINES; y++) begin
            for (int x = 0; x < COLS; x++) begin
                draw_bits(video_lfsr, 24, bits);
                capture[y][x] = bits[23:0];
                rgb   <= bits[23:0];
                hsync <= 1'b1;
                @(posedge rgb_clk);
            end
            hsync <= 1'b0;
            repeat (GAP) @(posedge rgb_clk);
        end
        vsync      <= 1'b0;
        rgb_enable <= 1'b0;
        // Last write and bank swap
        repeat (4) @(posedge rgb_clk);
        assert (frame_ready || !enable) else begin
            proto_errs++;
            $display("%s: frame_ready low after an enabled frame", test_name);
        end
        if (enable) begin
            for (int y = 0; y < LINES; y++)
                for (int x = 0; x < COLS; x++)
                    model[y][x] = capture[y][x];
        end
    endtask

    task automatic pulse_start(input int bc, input int bl);
        @(posedge rgb_clk);
        rd_block_col  <= block_col_t'(bc);
        rd_block_line <= block_line_t'(bl);
        rd_start      <= 1'b1;
        @(posedge rgb_clk);
        rd_start      <= 1'b0;
    endtask

    // Expected pixels are fixed when the read starts
    task automatic queue_block(input int bc, input int bl);
        for (int k = 0; k < `RGB_BLK_PIXELS; k++)
            exp_q.push_back(model[bl * `RGB_BLK_H + k / `RGB_BLK_W][bc * `RGB_BLK_W + k % `RGB_BLK_W]);
        reads_started++;
        pulse_start(bc, bl);
    endtask

    task automatic wait_done();
        wait (blocks_done == reads_started);
        wait (!rd_busy);
        assert (exp_q.size() == 0) else begin
            proto_errs++;
            $display("%s: read ended with %0d pixels missing", test_name, exp_q.size());
        end
    endtask

    task automatic read_block(input int bc, input int bl);
        queue_block(bc, bl);
        wait_done();
    endtask

    // Host credit return after a random delay of 0 to 3 cycles
    initial begin
        logic [31:0] delay;
        credit_return    = 1'b0;
        credits_returned = 0;
        credit_wait      = 0;
        credit_lfsr      = 16'd61422;
        forever begin
            @(posedge rgb_clk);
            if (nrst && !withhold && valid_seen > credits_returned) begin
                if (credit_wait > 0) begin
                    credit_wait--;
                    credit_return <= 1'b0;
                end else begin
                    credit_return <= 1'b1;
                    credits_returned++;
                    draw_bits(credit_lfsr, 2, delay);
                    credit_wait = delay;
                end
            end else
                credit_return <= 1'b0;
        end
    end

    // Scoreboard on the output stream
    initial begin
        pixel_t expected;
        valid_seen  = 0;
        read_count  = 0;
        blocks_done = 0;
        prev_last   = 1'b0;
        data_errs   = 0;
        credit_errs = 0;
        forever begin
            @(negedge rgb_clk);
            if (nrst) begin
                if (prev_last) begin
                    assert (!rd_busy) else begin
                        proto_errs++;
                        $display("%s: rd_busy still high after out_last", test_name);
                    end
                end
                prev_last = out_last;
                if (out_valid) begin
                    valid_seen++;
                    read_count++;
                    assert (valid_seen <= `RGB_CREDITS + credits_returned) else begin
                        credit_errs++;
                        $display("%s: pixel %0d sent with only %0d credits granted",
                                 test_name, valid_seen, `RGB_CREDITS + credits_returned);
                    end
                    assert (exp_q.size() > 0) else begin
                        proto_errs++;
                        $display("%s: out_valid with no read pending", test_name);
                    end
                    if (exp_q.size() > 0) begin
                        expected = exp_q.pop_front();
                        assert (out_data == expected) else begin
                            data_errs++;
                            $display("Fail %s: pixel %0d expected %h actual %h",
                                     test_name, read_count - 1, expected, out_data);
                        end
                    end
                    assert (out_last == (read_count == `RGB_BLK_PIXELS)) else begin
                        proto_errs++;
                        $display("Fail %s: out_last at pixel %0d expected %b actual %b",
                                 test_name, read_count - 1,
                                 read_count == `RGB_BLK_PIXELS, out_last);
                    end
                    if (read_count == `RGB_BLK_PIXELS) begin
                        read_count = 0;
                        blocks_done++;
                    end
                end else begin
                    assert (!out_last) else begin
                        proto_errs++;
                        $display("%s: out_last without out_valid", test_name);
                    end
                end
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge rgb_clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, a frame or a block read never finished", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int base;
        nrst          = 1'b0;
        rgb           = '0;
        hsync         = 1'b0;
        vsync         = 1'b0;
        rgb_enable    = 1'b0;
        rd_start      = 1'b0;
        rd_block_col  = '0;
        rd_block_line = '0;
        withhold      = 1'b0;
        reads_started = 0;
        proto_errs    = 0;
        video_lfsr    = 16'd61422;
        repeat (8) @(posedge rgb_clk);
        nrst <= 1'b1;

        test_name = "reset";
        @(negedge rgb_clk);
        assert (!out_valid && !out_last && !rd_busy && !frame_ready) else begin
            proto_errs++;
            $display("%s: outputs not idle after reset", test_name);
        end
        // No frame stored yet, so the start is dropped
        pulse_start(1, 1);
        repeat (20) @(posedge rgb_clk);
        @(negedge rgb_clk);
        assert (!rd_busy && valid_seen == 0) else begin
            proto_errs++;
            $display("%s: read accepted before the first frame", test_name);
        end

        test_name = "block_map";
        drive_frame(1'b1);
        for (int bl = 0; bl < `RGB_BLK_LINES; bl++)
            for (int bc = 0; bc < `RGB_BLK_COLS; bc++)
                read_block(bc, bl);

        test_name = "credit";
        wait (valid_seen == credits_returned);
        repeat (2) @(posedge rgb_clk);
        @(negedge rgb_clk);
        withhold = 1'b1;
        base     = valid_seen;
        queue_block(3, 2);
        repeat (60) @(posedge rgb_clk);
        assert (valid_seen - base == `RGB_CREDITS) else begin
            credit_errs++;
            $display("Fail %s: pixels while starved expected %0d actual %0d",
                     test_name, `RGB_CREDITS, valid_seen - base);
        end
        // Start while busy must not disturb the current block
        pulse_start(4, 3);
        @(negedge rgb_clk);
        withhold = 1'b0;
        wait_done();

        test_name = "enable_gate";
        drive_frame(1'b0);
        read_block(0, 0);
        read_block(4, 3);

        test_name = "read_during_capture";
        fork
            drive_frame(1'b1);
            begin
                repeat (30) @(posedge rgb_clk);
                read_block(2, 1);
            end
        join

        test_name = "after_capture";
        read_block(1, 2);
        read_block(3, 0);

        repeat (10) @(posedge rgb_clk);
        $display("Errors: data=%0d protocol=%0d credit=%0d", data_errs, proto_errs, credit_errs);
        if (data_errs + proto_errs + credit_errs == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/video_pkg.sv
verilog/mem_pkg.sv
verilog/rgb_logic.sv
verilog/frame_writer.sv
verilog/ram_arbiter.sv
verilog/frame_ram.sv
verilog/block_reader.sv
verilog/block_capture_top.sv
verification/tb_block_capture.sv

// ==== Bender.yml ====
package:
  name: block_capture

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/video_pkg.sv
      - verilog/mem_pkg.sv
      - verilog/rgb_logic.sv
      - verilog/frame_writer.sv
      - verilog/ram_arbiter.sv
      - verilog/frame_ram.sv
      - verilog/block_reader.sv
      - verilog/block_capture_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/tb_block_capture.sv
